//--- project.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/vector_register_file.sv
verilog/operand_fetch_stage.sv
verilog/single_cycle_execute_stage.sv
verilog/writeback_stage.sv
verilog/execute_pipeline.sv
verification/execute_pipeline_tb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' project.f)

.PHONY: run clean

run: obj_dir/Vexecute_pipeline_tb
	obj_dir/Vexecute_pipeline_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

obj_dir/Vexecute_pipeline_tb: project.f $(SOURCES) verilog/exec_macros.svh
	verilator --binary --timing --assert -f project.f \
		--top-module execute_pipeline_tb -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

//--- verification/execute_pipeline_tb.sv
////////////////////
// Self-checking testbench with a cycle-timed model of the 3-stage pipeline
// Register writes are modeled at the edge where they land, so no forwarding is assumed
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module execute_pipeline_tb import exec_pkg::*; ();

	typedef logic [`THREAD_IDX_WIDTH-1:0] thread_t;
	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [`DATA_WIDTH-1:0] lane_t;
	typedef logic [`VECTOR_WIDTH-1:0] vector_t;
	typedef logic [`VECTOR_LANES-1:0] mask_t;

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN = 4;

	// Issue cycles of each test including its drain
	localparam int IDLE_STEPS = 10;
	localparam int ALU_STEPS = 32 + 120 + DRAIN;
	localparam int COMPARE_STEPS = 4 + 4 + 160 + 40 + DRAIN;
	localparam int MASK_STEPS = 24 * 8 + DRAIN;
	localparam int BRANCH_STEPS = 16 + 4 + 28 * 4 + DRAIN;
	localparam int SQUASH_STEPS = 8 * 7 + DRAIN;
	localparam int TOTAL_STEPS = IDLE_STEPS + ALU_STEPS + COMPARE_STEPS + MASK_STEPS
		+ BRANCH_STEPS + SQUASH_STEPS;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_STEPS + 20;

	logic clk;
	logic reset;
	logic issue_valid;
	thread_t issue_thread;
	alu_op_t issue_alu_op;
	logic issue_is_branch;
	branch_type_t issue_branch_type;
	reg_idx_t issue_src1;
	reg_idx_t issue_src2;
	reg_idx_t issue_dest;
	logic issue_use_immediate;
	lane_t issue_immediate;
	lane_t issue_pc;
	mask_t issue_mask;

	logic wb_write_en;
	thread_t wb_thread;
	reg_idx_t wb_dest;
	vector_t wb_result;
	mask_t wb_mask;
	logic rollback_en;
	thread_t rollback_thread;
	lane_t rollback_pc;

	// Model state
	logic [31:0] lcg_state;
	int step;
	int error_count;
	int tests_failed;
	int errors_before;
	int kill_until [`THREAD_COUNT];
	vector_t shadow [`THREAD_COUNT][`REG_COUNT];

	// Expected wb records where index 3 is due at the outputs now
	logic exp_write_en [4];
	thread_t exp_thread [4];
	reg_idx_t exp_dest [4];
	mask_t exp_mask [4];
	vector_t exp_result [4];
	logic exp_rollback_en [4];
	thread_t exp_rollback_thread [4];
	lane_t exp_rollback_pc [4];

	execute_pipeline u_execute_pipeline
	(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_alu_op(issue_alu_op),
		.issue_is_branch(issue_is_branch),
		.issue_branch_type(issue_branch_type),
		.issue_src1(issue_src1),
		.issue_src2(issue_src2),
		.issue_dest(issue_dest),
		.issue_use_immediate(issue_use_immediate),
		.issue_immediate(issue_immediate),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.wb_write_en(wb_write_en),
		.wb_thread(wb_thread),
		.wb_dest(wb_dest),
		.wb_result(wb_result),
		.wb_mask(wb_mask),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Outputs change at the rising edge, so they are checked at the falling one
	a_write_en: assert property (@(negedge clk) disable iff (reset)
		wb_write_en == exp_write_en[3])
	else
	begin
		$display("[ERROR] wb_write_en: got %h expected %h", wb_write_en, exp_write_en[3]);
		error_count++;
	end

	a_wb_thread: assert property (@(negedge clk) disable iff (reset)
		!exp_write_en[3] || wb_thread == exp_thread[3])
	else
	begin
		$display("[ERROR] wb_thread: got %h expected %h", wb_thread, exp_thread[3]);
		error_count++;
	end

	a_wb_dest: assert property (@(negedge clk) disable iff (reset)
		!exp_write_en[3] || wb_dest == exp_dest[3])
	else
	begin
		$display("[ERROR] wb_dest: got %h expected %h", wb_dest, exp_dest[3]);
		error_count++;
	end

	a_wb_mask: assert property (@(negedge clk) disable iff (reset)
		!exp_write_en[3] || wb_mask == exp_mask[3])
	else
	begin
		$display("[ERROR] wb_mask: got %h expected %h", wb_mask, exp_mask[3]);
		error_count++;
	end

	a_wb_result: assert property (@(negedge clk) disable iff (reset)
		!exp_write_en[3] || wb_result == exp_result[3])
	else
	begin
		$display("[ERROR] wb_result: got %h expected %h", wb_result, exp_result[3]);
		error_count++;
	end

	a_rollback_en: assert property (@(negedge clk) disable iff (reset)
		rollback_en == exp_rollback_en[3])
	else
	begin
		$display("[ERROR] rollback_en: got %h expected %h", rollback_en, exp_rollback_en[3]);
		error_count++;
	end

	a_rollback_thread: assert property (@(negedge clk) disable iff (reset)
		!exp_rollback_en[3] || rollback_thread == exp_rollback_thread[3])
	else
	begin
		$display("[ERROR] rollback_thread: got %h expected %h", rollback_thread,
			exp_rollback_thread[3]);
		error_count++;
	end

	a_rollback_pc: assert property (@(negedge clk) disable iff (reset)
		!exp_rollback_en[3] || rollback_pc == exp_rollback_pc[3])
	else
	begin
		$display("[ERROR] rollback_pc: got %h expected %h", rollback_pc, exp_rollback_pc[3]);
		error_count++;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// The low LCG bits repeat quickly and are dropped
	function automatic int random_below(input int limit);
		return int'(next_random() >> 16) % limit;
	endfunction

	function automatic lane_t random_word();
		logic [31:0] high;
		logic [31:0] low;
		high = next_random() >> 16;
		low = next_random() >> 16;
		return {high[15:0], low[15:0]};
	endfunction

	function automatic lane_t lane_model(input alu_op_t alu_op, input lane_t a, input lane_t b);
		case (alu_op)
			op_copy: return b;
			op_or: return a | b;
			op_and: return a & b;
			op_uminus: return 32'd0 - b;
			op_xor: return a ^ b;
			op_iadd: return a + b;
			op_isub: return a - b;
			op_equal: return {31'd0, a == b};
			op_nequal: return {31'd0, a != b};
			op_sigtr: return {31'd0, $signed(a) > $signed(b)};
			op_sigte: return {31'd0, $signed(a) >= $signed(b)};
			op_silt: return {31'd0, $signed(a) < $signed(b)};
			op_silte: return {31'd0, $signed(a) <= $signed(b)};
			op_uigtr: return {31'd0, a > b};
			op_uigte: return {31'd0, a >= b};
			op_uilt: return {31'd0, a < b};
			op_uilte: return {31'd0, a <= b};
			default: return 32'd0;
		endcase
	endfunction

	function automatic vector_t vector_model(input alu_op_t alu_op, input vector_t a,
		input vector_t b);
		vector_t result;
		for (int lane = 0; lane < `VECTOR_LANES; lane++)
			result[lane*`DATA_WIDTH +: `DATA_WIDTH] = lane_model(alu_op,
				a[lane*`DATA_WIDTH +: `DATA_WIDTH], b[lane*`DATA_WIDTH +: `DATA_WIDTH]);
		return result;
	endfunction

	function automatic logic branch_model(input branch_type_t branch_type, input lane_t value);
		case (branch_type)
			branch_all: return value[15:0] == 16'hffff;
			branch_not_all: return value[15:0] == 16'h0000;
			branch_zero: return value == 32'd0;
			branch_not_zero: return value != 32'd0;
			default: return 1'b1;
		endcase
	endfunction

	// Drives one issue cycle and advances the model by one cycle
	task automatic issue_instr(input logic valid, input thread_t thread, input alu_op_t alu_op,
		input logic is_branch, input branch_type_t branch_type, input reg_idx_t src1,
		input reg_idx_t src2, input reg_idx_t dest, input logic use_immediate,
		input lane_t immediate, input mask_t mask);
		vector_t operand1;
		vector_t operand2;
		lane_t pc;
		logic live;

		@(posedge clk);
		#5;
		// The record from four issues ago lands in the register file at this edge
		if (exp_write_en[3])
		begin
			for (int lane = 0; lane < `VECTOR_LANES; lane++)
				if (exp_mask[3][lane])
					shadow[exp_thread[3]][exp_dest[3]][lane*`DATA_WIDTH +: `DATA_WIDTH] =
						exp_result[3][lane*`DATA_WIDTH +: `DATA_WIDTH];
		end
		for (int i = 3; i > 0; i--)
		begin
			exp_write_en[i] = exp_write_en[i-1];
			exp_thread[i] = exp_thread[i-1];
			exp_dest[i] = exp_dest[i-1];
			exp_mask[i] = exp_mask[i-1];
			exp_result[i] = exp_result[i-1];
			exp_rollback_en[i] = exp_rollback_en[i-1];
			exp_rollback_thread[i] = exp_rollback_thread[i-1];
			exp_rollback_pc[i] = exp_rollback_pc[i-1];
		end

		pc = random_word() & 32'hffff_fffc;
		operand1 = shadow[thread][src1];
		operand2 = use_immediate ? {`VECTOR_LANES{immediate}} : shadow[thread][src2];
		live = valid && step > kill_until[thread];

		exp_write_en[0] = live && !is_branch;
		exp_thread[0] = thread;
		exp_dest[0] = dest;
		exp_mask[0] = mask;
		exp_result[0] = vector_model(alu_op, operand1, operand2);
		exp_rollback_en[0] = live && is_branch && branch_model(branch_type,
			operand1[`DATA_WIDTH-1:0]);
		exp_rollback_thread[0] = thread;
		if (branch_type == branch_call_register)
			exp_rollback_pc[0] = operand1[`DATA_WIDTH-1:0];
		else
			exp_rollback_pc[0] = pc + immediate;

		// Taken branch cancels the next three issues of its thread
		if (exp_rollback_en[0])
			kill_until[thread] = step + 3;

		issue_valid = valid;
		issue_thread = thread;
		issue_alu_op = alu_op;
		issue_is_branch = is_branch;
		issue_branch_type = branch_type;
		issue_src1 = src1;
		issue_src2 = src2;
		issue_dest = dest;
		issue_use_immediate = use_immediate;
		issue_immediate = immediate;
		issue_pc = pc;
		issue_mask = mask;
		step++;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
			issue_instr(1'b0, '0, op_copy, 1'b0, branch_all, '0, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic random_alu_ops();
		for (int t = 0; t < `THREAD_COUNT; t++)
			for (int r = 0; r < `REG_COUNT; r++)
				issue_instr(1'b1, thread_t'(t), op_copy, 1'b0, branch_all, '0, '0,
					reg_idx_t'(r), 1'b1, random_word(), mask_t'(random_below(16)));
		repeat (120)
			issue_instr(1'b1, thread_t'(random_below(`THREAD_COUNT)),
				alu_op_t'(5'(random_below(7))), 1'b0, branch_all,
				reg_idx_t'(random_below(`REG_COUNT)), reg_idx_t'(random_below(`REG_COUNT)),
				reg_idx_t'(random_below(`REG_COUNT)), 1'(random_below(2)), random_word(),
				mask_t'(random_below(16)));
		idle_cycles(DRAIN);
	endtask

	task automatic compare_ops();
		lane_t edges [4];
		edges = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000};
		// Sign boundaries go to registers 0 to 3 of thread 2
		for (int e = 0; e < 4; e++)
			issue_instr(1'b1, thread_t'(2), op_copy, 1'b0, branch_all, '0, '0,
				reg_idx_t'(e), 1'b1, edges[e], '1);
		idle_cycles(4);
		for (int k = 0; k < 10; k++)
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					issue_instr(1'b1, thread_t'(2), alu_op_t'(5'(op_equal + k)), 1'b0,
						branch_all, reg_idx_t'(i), reg_idx_t'(j),
						reg_idx_t'(4 + random_below(4)), 1'b0, '0, '1);
		repeat (40)
			issue_instr(1'b1, thread_t'(random_below(`THREAD_COUNT)),
				alu_op_t'(5'(op_equal + random_below(10))), 1'b0, branch_all,
				reg_idx_t'(random_below(`REG_COUNT)), reg_idx_t'(random_below(`REG_COUNT)),
				reg_idx_t'(random_below(`REG_COUNT)), 1'(random_below(2)), random_word(),
				mask_t'(random_below(16)));
		idle_cycles(DRAIN);
	endtask

	task automatic masked_writes();
		thread_t thread;
		thread_t other;
		reg_idx_t dest;
		repeat (24)
		begin
			thread = thread_t'(random_below(`THREAD_COUNT));
			other = thread_t'(thread + 1);
			dest = reg_idx_t'(random_below(`REG_COUNT));
			issue_instr(1'b1, thread, op_copy, 1'b0, branch_all, '0, '0, dest, 1'b1,
				random_word(), mask_t'(random_below(16)));
			issue_instr(1'b1, other, op_copy, 1'b0, branch_all, '0, '0, dest, 1'b1,
				random_word(), mask_t'(random_below(16)));
			idle_cycles(4);
			// Copy back the whole register so every lane shows up on wb_result
			issue_instr(1'b1, thread, op_copy, 1'b0, branch_all, dest, dest, dest, 1'b0,
				'0, '1);
			issue_instr(1'b1, other, op_copy, 1'b0, branch_all, dest, dest, dest, 1'b0,
				'0, '1);
		end
		idle_cycles(DRAIN);
	endtask

	task automatic branch_types();
		lane_t values [4];
		values = '{32'h0000_ffff, 32'h0000_0000, 32'habcd_0000, 32'h0000_1234};
		for (int t = 0; t < `THREAD_COUNT; t++)
			for (int v = 0; v < 4; v++)
				issue_instr(1'b1, thread_t'(t), op_copy, 1'b0, branch_all, '0, '0,
					reg_idx_t'(4 + v), 1'b1, values[v], '1);
		idle_cycles(4);
		for (int b = 0; b < 7; b++)
			for (int v = 0; v < 4; v++)
			begin
				issue_instr(1'b1, thread_t'(b + v), op_iadd, 1'b1, branch_type_t'(3'(b)),
					reg_idx_t'(4 + v), '0, reg_idx_t'(random_below(`REG_COUNT)), 1'b1,
					random_word(), mask_t'(random_below(16)));
				idle_cycles(3);
			end
		idle_cycles(DRAIN);
	endtask

	task automatic rollback_squash();
		thread_t thread;
		thread_t other;
		for (int i = 0; i < 8; i++)
		begin
			thread = thread_t'(random_below(`THREAD_COUNT));
			other = thread_t'(thread + 1 + random_below(`THREAD_COUNT - 1));
			issue_instr(1'b1, thread, op_copy, 1'b1, branch_always, '0, '0, '0, 1'b1,
				random_word(), '0);
			issue_instr(1'b1, (i % 2 == 0) ? thread : other, op_iadd, 1'b0, branch_all,
				reg_idx_t'(random_below(`REG_COUNT)), '0,
				reg_idx_t'(random_below(`REG_COUNT)), 1'b1, random_word(), '1);
			issue_instr(1'b1, (i % 2 == 0) ? other : thread, op_xor, 1'b0, branch_all,
				reg_idx_t'(random_below(`REG_COUNT)), '0,
				reg_idx_t'(random_below(`REG_COUNT)), 1'b1, random_word(), '1);
			// This one is still at the issue port while the rollback is out
			issue_instr(1'b1, (i % 2 == 0) ? thread : other, op_or, 1'b0, branch_all,
				reg_idx_t'(random_below(`REG_COUNT)), '0,
				reg_idx_t'(random_below(`REG_COUNT)), 1'b1, random_word(), '1);
			idle_cycles(3);
		end
		idle_cycles(DRAIN);
	endtask

	task automatic report_test(input int number, input string name, input int start_errors);
		int errors;
		errors = error_count - start_errors;
		if (errors != 0)
			tests_failed++;
		$display("Test %0d %s: %s, %0d errors", number, name,
			(errors == 0) ? "passed" : "failed", errors);
	endtask

	initial
	begin
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_thread = '0;
		issue_alu_op = op_copy;
		issue_is_branch = 1'b0;
		issue_branch_type = branch_all;
		issue_src1 = '0;
		issue_src2 = '0;
		issue_dest = '0;
		issue_use_immediate = 1'b0;
		issue_immediate = '0;
		issue_pc = '0;
		issue_mask = '0;
		lcg_state = 32'd54;
		step = 0;
		error_count = 0;
		tests_failed = 0;
		for (int t = 0; t < `THREAD_COUNT; t++)
		begin
			kill_until[t] = -1;
			for (int r = 0; r < `REG_COUNT; r++)
				shadow[t][r] = '0;
		end
		for (int i = 0; i < 4; i++)
		begin
			exp_write_en[i] = 1'b0;
			exp_rollback_en[i] = 1'b0;
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;

		errors_before = error_count;
		idle_cycles(IDLE_STEPS);
		report_test(1, "idle after reset", errors_before);
		errors_before = error_count;
		random_alu_ops();
		report_test(2, "logic and arithmetic", errors_before);
		errors_before = error_count;
		compare_ops();
		report_test(3, "comparisons", errors_before);
		errors_before = error_count;
		masked_writes();
		report_test(4, "masked writes", errors_before);
		errors_before = error_count;
		branch_types();
		report_test(5, "branch types", errors_before);
		errors_before = error_count;
		rollback_squash();
		report_test(6, "rollback squash", errors_before);

		$display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/execute_pipeline.sv
////////////////////
// Fixed 3-cycle issue to writeback latency, no forwarding or interlocks
// A dependent issue must trail its producer by at least 4 cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module execute_pipeline import exec_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic issue_valid,
	input wire logic [`THREAD_IDX_WIDTH-1:0] issue_thread,
	input alu_op_t issue_alu_op,
	input wire logic issue_is_branch,
	input branch_type_t issue_branch_type,
	input wire logic [`REG_IDX_WIDTH-1:0] issue_src1,
	input wire logic [`REG_IDX_WIDTH-1:0] issue_src2,
	input wire logic [`REG_IDX_WIDTH-1:0] issue_dest,
	input wire logic issue_use_immediate,
	input wire logic [`DATA_WIDTH-1:0] issue_immediate,
	input wire logic [`DATA_WIDTH-1:0] issue_pc,
	input wire logic [`VECTOR_LANES-1:0] issue_mask,

	output logic wb_write_en,
	output logic [`THREAD_IDX_WIDTH-1:0] wb_thread,
	output logic [`REG_IDX_WIDTH-1:0] wb_dest,
	output logic [`VECTOR_WIDTH-1:0] wb_result,
	output logic [`VECTOR_LANES-1:0] wb_mask,
	output logic rollback_en,
	output logic [`THREAD_IDX_WIDTH-1:0] rollback_thread,
	output logic [`DATA_WIDTH-1:0] rollback_pc
);

	logic [`VECTOR_WIDTH-1:0] reg_data1;
	logic [`VECTOR_WIDTH-1:0] reg_data2;

	logic of_valid;
	logic [`THREAD_IDX_WIDTH-1:0] of_thread;
	alu_op_t of_alu_op;
	logic of_is_branch;
	branch_type_t of_branch_type;
	logic [`REG_IDX_WIDTH-1:0] of_dest;
	logic [`DATA_WIDTH-1:0] of_pc;
	logic [`DATA_WIDTH-1:0] of_immediate;
	logic [`VECTOR_LANES-1:0] of_mask;
	logic [`VECTOR_WIDTH-1:0] of_operand1;
	logic [`VECTOR_WIDTH-1:0] of_operand2;

	logic sc_valid;
	logic [`THREAD_IDX_WIDTH-1:0] sc_thread;
	logic [`REG_IDX_WIDTH-1:0] sc_dest;
	logic [`VECTOR_WIDTH-1:0] sc_result;
	logic [`VECTOR_LANES-1:0] sc_mask;
	logic sc_rollback_en;
	logic [`THREAD_IDX_WIDTH-1:0] sc_rollback_thread;
	logic [`DATA_WIDTH-1:0] sc_rollback_pc;

	// Read ports follow the issue directly, writes come from writeback
	vector_register_file u_vector_register_file
	(
		.clk(clk),
		.reset(reset),
		.read_thread(issue_thread),
		.read_src1(issue_src1),
		.read_src2(issue_src2),
		.write_en(wb_write_en),
		.write_thread(wb_thread),
		.write_dest(wb_dest),
		.write_data(wb_result),
		.write_mask(wb_mask),
		.read_data1(reg_data1),
		.read_data2(reg_data2)
	);

	operand_fetch_stage u_operand_fetch_stage
	(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_alu_op(issue_alu_op),
		.issue_is_branch(issue_is_branch),
		.issue_branch_type(issue_branch_type),
		.issue_dest(issue_dest),
		.issue_use_immediate(issue_use_immediate),
		.issue_immediate(issue_immediate),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.reg_data1(reg_data1),
		.reg_data2(reg_data2),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.of_valid(of_valid),
		.of_thread(of_thread),
		.of_alu_op(of_alu_op),
		.of_is_branch(of_is_branch),
		.of_branch_type(of_branch_type),
		.of_dest(of_dest),
		.of_pc(of_pc),
		.of_immediate(of_immediate),
		.of_mask(of_mask),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2)
	);

	single_cycle_execute_stage u_single_cycle_execute_stage
	(
		.clk(clk),
		.reset(reset),
		.of_valid(of_valid),
		.of_thread(of_thread),
		.of_alu_op(of_alu_op),
		.of_is_branch(of_is_branch),
		.of_branch_type(of_branch_type),
		.of_dest(of_dest),
		.of_pc(of_pc),
		.of_immediate(of_immediate),
		.of_mask(of_mask),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.sc_valid(sc_valid),
		.sc_thread(sc_thread),
		.sc_dest(sc_dest),
		.sc_result(sc_result),
		.sc_mask(sc_mask),
		.sc_rollback_en(sc_rollback_en),
		.sc_rollback_thread(sc_rollback_thread),
		.sc_rollback_pc(sc_rollback_pc)
	);

	writeback_stage u_writeback_stage
	(
		.clk(clk),
		.reset(reset),
		.sc_valid(sc_valid),
		.sc_thread(sc_thread),
		.sc_dest(sc_dest),
		.sc_result(sc_result),
		.sc_mask(sc_mask),
		.sc_rollback_en(sc_rollback_en),
		.sc_rollback_thread(sc_rollback_thread),
		.sc_rollback_pc(sc_rollback_pc),
		.wb_write_en(wb_write_en),
		.wb_thread(wb_thread),
		.wb_dest(wb_dest),
		.wb_result(wb_result),
		.wb_mask(wb_mask),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc)
	);

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
////////////////////
// Same-thread work already past execute is dropped while a rollback is out
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module writeback_stage
(
	input wire logic clk,
	input wire logic reset,

	input wire logic sc_valid,
	input wire logic [`THREAD_IDX_WIDTH-1:0] sc_thread,
	input wire logic [`REG_IDX_WIDTH-1:0] sc_dest,
	input wire logic [`VECTOR_WIDTH-1:0] sc_result,
	input wire logic [`VECTOR_LANES-1:0] sc_mask,
	input wire logic sc_rollback_en,
	input wire logic [`THREAD_IDX_WIDTH-1:0] sc_rollback_thread,
	input wire logic [`DATA_WIDTH-1:0] sc_rollback_pc,

	output logic wb_write_en,
	output logic [`THREAD_IDX_WIDTH-1:0] wb_thread,
	output logic [`REG_IDX_WIDTH-1:0] wb_dest,
	output logic [`VECTOR_WIDTH-1:0] wb_result,
	output logic [`VECTOR_LANES-1:0] wb_mask,
	output logic rollback_en,
	output logic [`THREAD_IDX_WIDTH-1:0] rollback_thread,
	output logic [`DATA_WIDTH-1:0] rollback_pc
);

	logic write_squashed;
	logic rollback_squashed;

	// The instruction right behind a taken branch was in execute before
	// the rollback went out, so it is caught here instead
	assign write_squashed = rollback_en && rollback_thread == sc_thread;
	assign rollback_squashed = rollback_en && rollback_thread == sc_rollback_thread;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb_write_en <= 1'b0;
			rollback_en <= 1'b0;
		end
		else
		begin
			// sc_valid is already low for branches
			wb_write_en <= sc_valid && !write_squashed;
			rollback_en <= sc_rollback_en && !rollback_squashed;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_thread <= sc_thread;
		wb_dest <= sc_dest;
		wb_result <= sc_result;
		wb_mask <= sc_mask;
		rollback_thread <= sc_rollback_thread;
		rollback_pc <= sc_rollback_pc;
	end

endmodule

`default_nettype wire

//--- verilog/single_cycle_execute_stage.sv
////////////////////
// Branches leave sc_valid low and report only through the rollback outputs
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module single_cycle_execute_stage import exec_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic of_valid,
	input wire logic [`THREAD_IDX_WIDTH-1:0] of_thread,
	input alu_op_t of_alu_op,
	input wire logic of_is_branch,
	input branch_type_t of_branch_type,
	input wire logic [`REG_IDX_WIDTH-1:0] of_dest,
	input wire logic [`DATA_WIDTH-1:0] of_pc,
	input wire logic [`DATA_WIDTH-1:0] of_immediate,
	input wire logic [`VECTOR_LANES-1:0] of_mask,
	input wire logic [`VECTOR_WIDTH-1:0] of_operand1,
	input wire logic [`VECTOR_WIDTH-1:0] of_operand2,

	input wire logic rollback_en,
	input wire logic [`THREAD_IDX_WIDTH-1:0] rollback_thread,

	output logic sc_valid,
	output logic [`THREAD_IDX_WIDTH-1:0] sc_thread,
	output logic [`REG_IDX_WIDTH-1:0] sc_dest,
	output logic [`VECTOR_WIDTH-1:0] sc_result,
	output logic [`VECTOR_LANES-1:0] sc_mask,
	output logic sc_rollback_en,
	output logic [`THREAD_IDX_WIDTH-1:0] sc_rollback_thread,
	output logic [`DATA_WIDTH-1:0] sc_rollback_pc
);

	localparam int MSB = `DATA_WIDTH - 1;

	logic [`VECTOR_WIDTH-1:0] vector_result;
	logic [`DATA_WIDTH-1:0] branch_value;
	logic branch_taken;
	logic squashed;

	genvar lane;
	generate
		for (lane = 0; lane < `VECTOR_LANES; lane++)
		begin : lane_alu
			logic [`DATA_WIDTH-1:0] op_a;
			logic [`DATA_WIDTH-1:0] op_b;
			logic [`DATA_WIDTH:0] difference;
			logic borrow;
			logic negative;
			logic overflow;
			logic zero;
			logic signed_lt;
			logic signed_gtr;
			logic [`DATA_WIDTH-1:0] lane_result;

			assign op_a = of_operand1[lane*`DATA_WIDTH +: `DATA_WIDTH];
			assign op_b = of_operand2[lane*`DATA_WIDTH +: `DATA_WIDTH];

			// One subtract feeds every comparison; the extra bit is the borrow
			assign difference = {1'b0, op_a} - {1'b0, op_b};
			assign borrow = difference[`DATA_WIDTH];
			assign negative = difference[MSB];
			assign zero = difference[MSB:0] == '0;
			assign overflow = op_a[MSB] != op_b[MSB] && negative != op_a[MSB];
			assign signed_lt = negative ^ overflow;
			assign signed_gtr = !signed_lt && !zero;

			always_comb
			begin
				case (of_alu_op)
					op_copy: lane_result = op_b;
					op_or: lane_result = op_a | op_b;
					op_and: lane_result = op_a & op_b;
					op_uminus: lane_result = -op_b;
					op_xor: lane_result = op_a ^ op_b;
					op_iadd: lane_result = op_a + op_b;
					op_isub: lane_result = difference[MSB:0];
					op_equal: lane_result = {{MSB{1'b0}}, zero};
					op_nequal: lane_result = {{MSB{1'b0}}, !zero};
					op_sigtr: lane_result = {{MSB{1'b0}}, signed_gtr};
					op_sigte: lane_result = {{MSB{1'b0}}, !signed_lt};
					op_silt: lane_result = {{MSB{1'b0}}, signed_lt};
					op_silte: lane_result = {{MSB{1'b0}}, signed_lt || zero};
					op_uigtr: lane_result = {{MSB{1'b0}}, !borrow && !zero};
					op_uigte: lane_result = {{MSB{1'b0}}, !borrow};
					op_uilt: lane_result = {{MSB{1'b0}}, borrow};
					op_uilte: lane_result = {{MSB{1'b0}}, borrow || zero};
					default: lane_result = '0;
				endcase
			end

			assign vector_result[lane*`DATA_WIDTH +: `DATA_WIDTH] = lane_result;
		end
	endgenerate

	// Branch conditions look only at lane 0 of operand 1
	assign branch_value = of_operand1[`DATA_WIDTH-1:0];

	always_comb
	begin
		case (of_branch_type)
			branch_all: branch_taken = branch_value[15:0] == 16'hffff;
			branch_zero: branch_taken = branch_value == '0;
			branch_not_zero: branch_taken = branch_value != '0;
			branch_always: branch_taken = 1'b1;
			branch_call_offset: branch_taken = 1'b1;
			branch_not_all: branch_taken = branch_value[15:0] == 16'h0000;
			branch_call_register: branch_taken = 1'b1;
			default: branch_taken = 1'b0;
		endcase
	end

	assign squashed = rollback_en && rollback_thread == of_thread;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sc_valid <= 1'b0;
			sc_rollback_en <= 1'b0;
		end
		else
		begin
			sc_valid <= of_valid && !squashed && !of_is_branch;
			sc_rollback_en <= of_valid && !squashed && of_is_branch && branch_taken;
		end
	end

	always_ff @(posedge clk)
	begin
		sc_thread <= of_thread;
		sc_dest <= of_dest;
		sc_result <= vector_result;
		sc_mask <= of_mask;
		sc_rollback_thread <= of_thread;

		// Register calls jump to the value, all others are pc relative
		if (of_branch_type == branch_call_register)
			sc_rollback_pc <= branch_value;
		else
			sc_rollback_pc <= of_pc + of_immediate;
	end

endmodule

`default_nettype wire

//--- verilog/operand_fetch_stage.sv
////////////////////
// Register data must already be read with the issue's own thread and sources
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module operand_fetch_stage import exec_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Issue group from the front end
	input wire logic issue_valid,
	input wire logic [`THREAD_IDX_WIDTH-1:0] issue_thread,
	input alu_op_t issue_alu_op,
	input wire logic issue_is_branch,
	input branch_type_t issue_branch_type,
	input wire logic [`REG_IDX_WIDTH-1:0] issue_dest,
	input wire logic issue_use_immediate,
	input wire logic [`DATA_WIDTH-1:0] issue_immediate,
	input wire logic [`DATA_WIDTH-1:0] issue_pc,
	input wire logic [`VECTOR_LANES-1:0] issue_mask,
	input wire logic [`VECTOR_WIDTH-1:0] reg_data1,
	input wire logic [`VECTOR_WIDTH-1:0] reg_data2,

	input wire logic rollback_en,
	input wire logic [`THREAD_IDX_WIDTH-1:0] rollback_thread,

	output logic of_valid,
	output logic [`THREAD_IDX_WIDTH-1:0] of_thread,
	output alu_op_t of_alu_op,
	output logic of_is_branch,
	output branch_type_t of_branch_type,
	output logic [`REG_IDX_WIDTH-1:0] of_dest,
	output logic [`DATA_WIDTH-1:0] of_pc,
	output logic [`DATA_WIDTH-1:0] of_immediate,
	output logic [`VECTOR_LANES-1:0] of_mask,
	output logic [`VECTOR_WIDTH-1:0] of_operand1,
	output logic [`VECTOR_WIDTH-1:0] of_operand2
);

	logic squashed;

	// Only the thread being rolled back loses its issue
	assign squashed = rollback_en && rollback_thread == issue_thread;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			of_valid <= 1'b0;
		else
			of_valid <= issue_valid && !squashed;
	end

	always_ff @(posedge clk)
	begin
		of_thread <= issue_thread;
		of_alu_op <= issue_alu_op;
		of_is_branch <= issue_is_branch;
		of_branch_type <= issue_branch_type;
		of_dest <= issue_dest;
		of_pc <= issue_pc;
		of_immediate <= issue_immediate;
		of_mask <= issue_mask;
		of_operand1 <= reg_data1;

		// Immediate is broadcast to every lane
		if (issue_use_immediate)
			of_operand2 <= {`VECTOR_LANES{issue_immediate}};
		else
			of_operand2 <= reg_data2;
	end

endmodule

`default_nettype wire

//--- verilog/vector_register_file.sv
////////////////////
// Two combinational read ports, one lane-masked write port
// A write is visible to reads only after the clock edge
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module vector_register_file
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [`THREAD_IDX_WIDTH-1:0] read_thread,
	input wire logic [`REG_IDX_WIDTH-1:0] read_src1,
	input wire logic [`REG_IDX_WIDTH-1:0] read_src2,
	input wire logic write_en,
	input wire logic [`THREAD_IDX_WIDTH-1:0] write_thread,
	input wire logic [`REG_IDX_WIDTH-1:0] write_dest,
	input wire logic [`VECTOR_WIDTH-1:0] write_data,
	input wire logic [`VECTOR_LANES-1:0] write_mask,
	output logic [`VECTOR_WIDTH-1:0] read_data1,
	output logic [`VECTOR_WIDTH-1:0] read_data2
);

	localparam int ENTRIES = `THREAD_COUNT * `REG_COUNT;

	// Entry index is {thread, register}
	logic [`VECTOR_WIDTH-1:0] registers [ENTRIES];

	assign read_data1 = registers[{read_thread, read_src1}];
	assign read_data2 = registers[{read_thread, read_src2}];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int entry = 0; entry < ENTRIES; entry++)
				registers[entry] <= '0;
		end
		else if (write_en)
		begin
			// Lanes with a clear mask bit keep their old value
			for (int lane = 0; lane < `VECTOR_LANES; lane++)
			begin
				if (write_mask[lane])
					registers[{write_thread, write_dest}][lane*`DATA_WIDTH +: `DATA_WIDTH]
						<= write_data[lane*`DATA_WIDTH +: `DATA_WIDTH];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exec_pkg.sv
////////////////////
// Opcode encodings shared by the front end and the execute back end
////////////////////

`default_nettype none

package exec_pkg;

	// Single-cycle lane operations. Comparisons yield 1 or 0 per lane
	typedef enum logic [4:0]
	{
		op_copy,
		op_or,
		op_and,
		op_uminus,
		op_xor,
		op_iadd,
		op_isub,
		op_equal,
		op_nequal,
		op_sigtr,
		op_sigte,
		op_silt,
		op_silte,
		op_uigtr,
		op_uigte,
		op_uilt,
		op_uilte
	} alu_op_t;

	// Branch conditions tested on lane 0 of operand 1
	typedef enum logic [2:0]
	{
		branch_all,
		branch_zero,
		branch_not_zero,
		branch_always,
		branch_call_offset,
		branch_not_all,
		branch_call_register
	} branch_type_t;

endpackage

`default_nettype wire

//--- verilog/exec_macros.svh
////////////////////
// Core sizing. Index widths are derived, so counts must be powers of two
////////////////////

`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

`define VECTOR_LANES 4
`define THREAD_COUNT 4
`define REG_COUNT 8
`define DATA_WIDTH 32

// Derived widths
`define THREAD_IDX_WIDTH $clog2(`THREAD_COUNT)
`define REG_IDX_WIDTH $clog2(`REG_COUNT)

// Flattened vector with lane 0 in the low bits
`define VECTOR_WIDTH (`VECTOR_LANES * `DATA_WIDTH)

`endif
